// ==== rtl/conv_pkg.sv ====
package conv_pkg;

    localparam int PIXEL_W = 16;
    typedef logic signed [PIXEL_W-1:0] pixel_t;
    localparam int FRAC_BITS = 8;                   // coefficient fraction bits

    localparam int KSIZE = 3;
    localparam int KWORDS = KSIZE * KSIZE;
    localparam int COEF_IDX_W = $clog2(KWORDS);

    localparam int MAX_RES = 64;
    localparam int RES_W = 7;                       // side plus padding
    typedef logic [RES_W-1:0] res_t;

    // image side per select code
    localparam int RES_SEL_W = 2;
    localparam res_t RES_TABLE [2**RES_SEL_W] = '{7'd8, 7'd16, 7'd32, 7'd64};

    localparam int ROWSUM_W = 2 * PIXEL_W + 2;
    typedef logic signed [ROWSUM_W-1:0] rowsum_t;

    localparam int ADDR_W = 32;
    localparam int BURST_W = 7;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int FIFO_DEPTH = MAX_RES;            // one row

    localparam int CSR_ADDR_W = 3;
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL = 3'd0;
    localparam logic [CSR_ADDR_W-1:0] CSR_RES = 3'd1;
    localparam logic [CSR_ADDR_W-1:0] CSR_SRC = 3'd2;
    localparam logic [CSR_ADDR_W-1:0] CSR_DST = 3'd3;
    localparam logic [CSR_ADDR_W-1:0] CSR_KER = 3'd4;

endpackage

// ==== rtl/conv_csr.sv ====
`timescale 1ns/100ps

module conv_csr import conv_pkg::*; (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic [CSR_ADDR_W-1:0] s_address,
    input  logic [31:0]           s_writedata,
    output logic [31:0]           s_readdata,
    input  logic                  s_read,
    input  logic                  s_write,
    output logic                  s_waitrequest,
    input  logic                  busy,
    output logic                  go,
    output logic [RES_SEL_W-1:0]  res_sel,
    output logic [ADDR_W-1:0]     src_addr,
    output logic [ADDR_W-1:0]     dst_addr,
    output logic [ADDR_W-1:0]     ker_addr
);
    logic read_ack;
    logic cfg_write;

    assign s_waitrequest = s_read & ~read_ack;      // one wait state per read
    assign cfg_write = s_write & ~busy;             // config frozen while running

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_ack <= 1'b0;
            go <= 1'b0;
            res_sel <= '0;
            src_addr <= '0;
            dst_addr <= '0;
            ker_addr <= '0;
        end
        else begin
            read_ack <= s_read & ~read_ack;
            go <= s_write & (s_address == CSR_CTRL) & s_writedata[0];
            if (cfg_write) begin
                case (s_address)
                    CSR_RES: res_sel <= s_writedata[RES_SEL_W-1:0];
                    CSR_SRC: src_addr <= s_writedata;
                    CSR_DST: dst_addr <= s_writedata;
                    CSR_KER: ker_addr <= s_writedata;
                    default: ;
                endcase
            end
        end
    end

    // captured during the wait state
    always_ff @(posedge clock) begin
        case (s_address)
            CSR_CTRL: s_readdata <= {31'd0, busy};
            CSR_RES:  s_readdata <= 32'(res_sel);
            CSR_SRC:  s_readdata <= src_addr;
            CSR_DST:  s_readdata <= dst_addr;
            CSR_KER:  s_readdata <= ker_addr;
            default:  s_readdata <= '0;
        endcase
    end

endmodule

// ==== rtl/conv_fifo.sv ====
`timescale 1ns/100ps

module conv_fifo import conv_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic                clock,
    input  logic                clock_sreset,
    input  logic                wr,
    input  pixel_t              wdata,
    input  logic                rd,
    output pixel_t              rdata,
    output logic [BURST_W-1:0]  count
);
    localparam int PTR_W = $clog2(DEPTH);

    pixel_t           mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;

    assign rdata = mem[rptr];                       // show-ahead

    always_ff @(posedge clock) begin
        if (wr) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end
        else begin
            if (wr) begin
                wptr <= wptr + 1'b1;
            end
            if (rd) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + {{(BURST_W-1){1'b0}}, wr} - {{(BURST_W-1){1'b0}}, rd};
        end
    end

endmodule

// ==== rtl/conv_sequencer.sv ====
`timescale 1ns/100ps

module conv_sequencer import conv_pkg::*; (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic                  go,
    input  logic [RES_SEL_W-1:0]  res_sel,
    input  logic [ADDR_W-1:0]     src_addr,
    input  logic [ADDR_W-1:0]     dst_addr,
    input  logic [ADDR_W-1:0]     ker_addr,
    output logic                  busy,
    output logic [ADDR_W-1:0]     m_address,
    output logic [BURST_W-1:0]    m_burstcount,
    output logic                  m_read,
    output logic                  m_write,
    input  logic                  m_readdatavalid,
    input  logic                  m_waitrequest,
    input  logic [BURST_W-1:0]    src_count,
    input  pixel_t                src_q,
    output logic                  src_rd,
    output logic                  src_wr,
    output logic                  coef_valid,
    output logic [COEF_IDX_W-1:0] coef_index,
    output pixel_t                feed_pixel,
    output logic                  feed_valid,
    output logic                  feed_row_start,
    input  logic [BURST_W-1:0]    res_count,
    output logic                  res_rd
);
    typedef enum logic [2:0] {S_IDLE, S_KER, S_ROW, S_READ, S_FEED, S_WAIT, S_WRITE} state_t;

    state_t            state;
    res_t              side;
    res_t              row;                         // padded row 0 .. side+1
    res_t              col;
    res_t              word_cnt;
    logic [ADDR_W-1:0] src_ptr;
    logic [ADDR_W-1:0] dst_ptr;
    logic [ADDR_W-1:0] stride;
    logic              border;
    logic              interior;

    assign stride = ADDR_W'(side) * ADDR_W'(BYTES_PER_PIXEL);
    assign border = (row == '0) || (row == side + 1'b1);
    assign interior = ~border && (col != '0) && (col != side + 1'b1);

    always_comb begin
        coef_valid = (state == S_KER) & m_readdatavalid;
        coef_index = word_cnt[COEF_IDX_W-1:0];
        src_wr = (state == S_READ) & m_readdatavalid;
        feed_valid = (state == S_FEED);
        feed_row_start = feed_valid & (col == '0);
        src_rd = feed_valid & interior;
        feed_pixel = src_rd ? src_q : '0;           // zero border
        res_rd = m_write & ~m_waitrequest;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= S_IDLE;
            busy <= 1'b0;
            m_read <= 1'b0;
            m_write <= 1'b0;
        end
        else begin
            if (m_read && !m_waitrequest) begin
                m_read <= 1'b0;                     // request taken
            end
            case (state)
                S_IDLE: begin
                    if (go) begin
                        busy <= 1'b1;
                        side <= RES_TABLE[res_sel];
                        src_ptr <= src_addr;
                        dst_ptr <= dst_addr;
                        m_address <= ker_addr;
                        m_burstcount <= BURST_W'(KWORDS);
                        m_read <= 1'b1;
                        word_cnt <= '0;
                        state <= S_KER;
                    end
                end
                S_KER: begin
                    if (m_readdatavalid) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == KWORDS - 1) begin
                            row <= '0;
                            state <= S_ROW;
                        end
                    end
                end
                S_ROW: begin
                    col <= '0;
                    if (border) begin
                        state <= S_FEED;
                    end
                    else begin
                        m_address <= src_ptr;
                        m_burstcount <= side;
                        m_read <= 1'b1;
                        src_ptr <= src_ptr + stride;
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (src_count == side) begin    // whole row buffered
                        state <= S_FEED;
                    end
                end
                S_FEED: begin
                    col <= col + 1'b1;
                    if (col == side + 1'b1) begin
                        if (row >= 2) begin
                            state <= S_WAIT;
                        end
                        else begin
                            row <= row + 1'b1;
                            state <= S_ROW;
                        end
                    end
                end
                S_WAIT: begin
                    if (res_count == side) begin
                        m_address <= dst_ptr;
                        m_burstcount <= side;
                        m_write <= 1'b1;
                        dst_ptr <= dst_ptr + stride;
                        word_cnt <= '0;
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (!m_waitrequest) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == side - 1'b1) begin
                            m_write <= 1'b0;
                            if (row == side + 1'b1) begin
                                busy <= 1'b0;
                                state <= S_IDLE;
                            end
                            else begin
                                row <= row + 1'b1;
                                state <= S_ROW;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/conv_line_window.sv ====
`timescale 1ns/100ps

module conv_line_window import conv_pkg::*; (
    input  logic               clock,
    input  logic               clock_sreset,
    input  pixel_t             feed_pixel,
    input  logic               feed_valid,
    input  logic               feed_row_start,
    output pixel_t [KSIZE-1:0] tap_row0,
    output pixel_t [KSIZE-1:0] tap_row1,
    output pixel_t [KSIZE-1:0] tap_row2,
    output logic               win_valid
);
    pixel_t line0 [MAX_RES+2];                      // padded row r-2
    pixel_t line1 [MAX_RES+2];                      // padded row r-1
    res_t   col_cnt;
    res_t   row_cnt;
    res_t   width;                                  // padded row length
    res_t   cur_col;
    res_t   cur_row;

    assign cur_col = feed_row_start ? '0 : col_cnt;

    // square frame, so the row count wraps at the padded width
    always_comb begin
        cur_row = row_cnt;
        if (feed_row_start) begin
            cur_row = (row_cnt == width - 1'b1) ? '0 : row_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            col_cnt <= '0;
            row_cnt <= '1;                          // first row start wraps to 0
            width <= '0;
            win_valid <= 1'b0;
        end
        else begin
            win_valid <= feed_valid & (cur_row >= 2) & (cur_col >= 2);
            if (feed_valid) begin
                col_cnt <= cur_col + 1'b1;
                row_cnt <= cur_row;
                if (feed_row_start) begin
                    width <= col_cnt;
                end
            end
        end
    end

    // tap [0] is the oldest column
    always_ff @(posedge clock) begin
        if (feed_valid) begin
            line0[cur_col] <= line1[cur_col];
            line1[cur_col] <= feed_pixel;
            tap_row0 <= {line0[cur_col], tap_row0[KSIZE-1:1]};
            tap_row1 <= {line1[cur_col], tap_row1[KSIZE-1:1]};
            tap_row2 <= {feed_pixel, tap_row2[KSIZE-1:1]};
        end
    end

endmodule

// ==== rtl/conv_row_mac.sv ====
`timescale 1ns/100ps

module conv_row_mac import conv_pkg::*; #(
    parameter int ROW = 0
) (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic                  coef_valid,
    input  logic [COEF_IDX_W-1:0] coef_index,
    input  pixel_t                coef,
    input  pixel_t [KSIZE-1:0]    taps,
    input  logic                  win_valid,
    output rowsum_t               row_sum,
    output logic                  row_valid
);
    pixel_t                      coefs [KSIZE];
    logic signed [2*PIXEL_W-1:0] prod [KSIZE];
    logic                        prod_valid;
    rowsum_t                     sum;

    always_comb begin
        sum = '0;
        for (int j = 0; j < KSIZE; j++) begin
            sum = sum + rowsum_t'(prod[j]);
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < KSIZE; j++) begin
            if (coef_valid && coef_index == ROW * KSIZE + j) begin
                coefs[j] <= coef;                   // row-major kernel order
            end
            prod[j] <= taps[j] * coefs[j];
        end
        row_sum <= sum;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            prod_valid <= 1'b0;
            row_valid <= 1'b0;
        end
        else begin
            prod_valid <= win_valid;
            row_valid <= prod_valid;
        end
    end

endmodule

// ==== rtl/conv_row_sum.sv ====
`timescale 1ns/100ps

module conv_row_sum import conv_pkg::*; (
    input  logic    clock,
    input  logic    clock_sreset,
    input  rowsum_t row_sum0,
    input  rowsum_t row_sum1,
    input  rowsum_t row_sum2,
    input  logic    row_valid,
    output logic    res_wr,
    output pixel_t  res_data
);
    logic signed [ROWSUM_W+1:0] total;

    assign total = row_sum0 + row_sum1 + row_sum2;

    // drop the fraction, upper bits wrap
    always_ff @(posedge clock) begin
        res_data <= pixel_t'(total >>> FRAC_BITS);
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            res_wr <= 1'b0;
        end
        else begin
            res_wr <= row_valid;
        end
    end

endmodule

// ==== rtl/conv_burst_top.sv ====
`timescale 1ns/100ps

module conv_burst_top import conv_pkg::*; (
    input  logic                  clock,
    input  logic                  clock_sreset,
    input  logic [CSR_ADDR_W-1:0] s_address,
    input  logic [31:0]           s_writedata,
    output logic [31:0]           s_readdata,
    input  logic                  s_read,
    input  logic                  s_write,
    output logic                  s_waitrequest,
    output logic [ADDR_W-1:0]     m_address,
    input  pixel_t                m_readdata,
    output pixel_t                m_writedata,
    output logic [BURST_W-1:0]    m_burstcount,
    output logic                  m_read,
    output logic                  m_write,
    input  logic                  m_readdatavalid,
    input  logic                  m_waitrequest
);
    logic                  go;
    logic                  busy;
    logic [RES_SEL_W-1:0]  res_sel;
    logic [ADDR_W-1:0]     src_addr;
    logic [ADDR_W-1:0]     dst_addr;
    logic [ADDR_W-1:0]     ker_addr;
    logic                  src_rd;
    logic                  src_wr;
    logic [BURST_W-1:0]    src_count;
    pixel_t                src_q;
    logic                  res_rd;
    logic                  res_wr;
    pixel_t                res_data;
    logic [BURST_W-1:0]    res_count;
    logic                  coef_valid;
    logic [COEF_IDX_W-1:0] coef_index;
    pixel_t                feed_pixel;
    logic                  feed_valid;
    logic                  feed_row_start;
    pixel_t [KSIZE-1:0]    taps [KSIZE];
    logic                  win_valid;
    rowsum_t               row_sum [KSIZE];
    logic                  row_valid [KSIZE];

    conv_csr u_csr (
        .clock,
        .clock_sreset,
        .s_address,
        .s_writedata,
        .s_readdata,
        .s_read,
        .s_write,
        .s_waitrequest,
        .busy,
        .go,
        .res_sel,
        .src_addr,
        .dst_addr,
        .ker_addr
    );

    conv_sequencer u_sequencer (
        .clock,
        .clock_sreset,
        .go,
        .res_sel,
        .src_addr,
        .dst_addr,
        .ker_addr,
        .busy,
        .m_address,
        .m_burstcount,
        .m_read,
        .m_write,
        .m_readdatavalid,
        .m_waitrequest,
        .src_count,
        .src_q,
        .src_rd,
        .src_wr,
        .coef_valid,
        .coef_index,
        .feed_pixel,
        .feed_valid,
        .feed_row_start,
        .res_count,
        .res_rd
    );

    conv_fifo #(.DEPTH(FIFO_DEPTH)) u_src_fifo (
        .clock,
        .clock_sreset,
        .wr    (src_wr),
        .wdata (m_readdata),
        .rd    (src_rd),
        .rdata (src_q),
        .count (src_count)
    );

    conv_fifo #(.DEPTH(FIFO_DEPTH)) u_res_fifo (
        .clock,
        .clock_sreset,
        .wr    (res_wr),
        .wdata (res_data),
        .rd    (res_rd),
        .rdata (m_writedata),
        .count (res_count)
    );

    conv_line_window u_line_window (
        .clock,
        .clock_sreset,
        .feed_pixel,
        .feed_valid,
        .feed_row_start,
        .tap_row0 (taps[0]),
        .tap_row1 (taps[1]),
        .tap_row2 (taps[2]),
        .win_valid
    );

    for (genvar i = 0; i < KSIZE; i++) begin : g_row
        conv_row_mac #(.ROW(i)) u_row_mac (
            .clock,
            .clock_sreset,
            .coef_valid,
            .coef_index,
            .coef      (m_readdata),
            .taps      (taps[i]),
            .win_valid,
            .row_sum   (row_sum[i]),
            .row_valid (row_valid[i])
        );
    end

    // sum is taken once every row MAC has its result
    conv_row_sum u_row_sum (
        .clock,
        .clock_sreset,
        .row_sum0  (row_sum[0]),
        .row_sum1  (row_sum[1]),
        .row_sum2  (row_sum[2]),
        .row_valid (row_valid[0] & row_valid[1] & row_valid[2]),
        .res_wr,
        .res_data
    );

endmodule

// ==== dv/conv_mem_model.sv ====
`timescale 1ns/100ps

module conv_mem_model import conv_pkg::*; #(
    parameter int          WORDS = 16384,
    parameter logic [31:0] SEED = 32'h797c_9d89
) (
    input  logic               clock,
    input  logic               clock_sreset,
    input  logic               stall_enable,
    input  logic [ADDR_W-1:0]  address,
    input  logic [BURST_W-1:0] burstcount,
    input  logic               read,
    input  logic               write,
    input  pixel_t             writedata,
    output pixel_t             readdata,
    output logic               readdatavalid,
    output logic               waitrequest
);
    localparam int IDX_W = $clog2(WORDS);

    pixel_t           mem [WORDS];                  // word per 16-bit pixel
    int               seed = SEED;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    int               rd_left;
    int               rd_delay;
    int               wr_beat;

    assign wr_idx = address[IDX_W:1] + IDX_W'(wr_beat);

    always @(posedge clock) begin
        if (clock_sreset) begin
            waitrequest <= 1'b0;
            readdatavalid <= 1'b0;
            rd_left <= 0;
            rd_delay <= 0;
            wr_beat <= 0;
        end
        else begin
            waitrequest <= stall_enable && (($random(seed) & 3) == 0);
            readdatavalid <= 1'b0;
            if (read && !waitrequest) begin
                rd_idx <= address[IDX_W:1];
                rd_left <= int'(burstcount);
                rd_delay <= stall_enable ? ($random(seed) & 7) : 0;  // first word latency
            end
            else if (rd_left != 0) begin
                if (rd_delay != 0) begin
                    rd_delay <= rd_delay - 1;
                end
                // gaps inside the burst when stalling
                else if (!stall_enable || ($random(seed) & 3) != 0) begin
                    readdata <= mem[rd_idx];
                    readdatavalid <= 1'b1;
                    rd_idx <= rd_idx + 1'b1;
                    rd_left <= rd_left - 1;
                end
            end
            if (write && !waitrequest) begin
                mem[wr_idx] = writedata;
                wr_beat <= (wr_beat == int'(burstcount) - 1) ? 0 : wr_beat + 1;
            end
        end
    end

endmodule

// ==== dv/conv_burst_tb.sv ====
`timescale 1ns/100ps

module conv_burst_tb import conv_pkg::*; ();

    localparam int CLK_HALF = 20;
    localparam int MEM_WORDS = 16384;
    localparam logic [31:0] RAND_SEED = 32'h797c_9d89;
    localparam int NUM_TESTS = 6;
    localparam int SIDE_USED_MAX = 16;
    localparam int FRAME_CYCLES = (SIDE_USED_MAX + 2) * (3 * SIDE_USED_MAX + 24) + 64;
    localparam int LATENCY_MARGIN = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * FRAME_CYCLES * LATENCY_MARGIN;

    localparam logic [ADDR_W-1:0] KER_A = 32'h0000_0100;
    localparam logic [ADDR_W-1:0] SRC_A = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] DST_A = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] KER_B = 32'h0000_0200;
    localparam logic [ADDR_W-1:0] SRC_B = 32'h0000_4000;
    localparam logic [ADDR_W-1:0] DST_B = 32'h0000_6000;

    logic                  clock;
    logic                  clock_sreset;
    logic [CSR_ADDR_W-1:0] s_address;
    logic [31:0]           s_writedata;
    logic [31:0]           s_readdata;
    logic                  s_read;
    logic                  s_write;
    logic                  s_waitrequest;
    logic [ADDR_W-1:0]     m_address;
    pixel_t                m_readdata;
    pixel_t                m_writedata;
    logic [BURST_W-1:0]    m_burstcount;
    logic                  m_read;
    logic                  m_write;
    logic                  m_readdatavalid;
    logic                  m_waitrequest;
    logic                  stall_enable;

    int                seed = RAND_SEED;
    int                errors;
    int                checks;
    int                tests;
    pixel_t            img [MAX_RES*MAX_RES];
    pixel_t            ker [KWORDS];
    pixel_t            snapshot [MEM_WORDS];
    pixel_t            prev_result [MAX_RES*MAX_RES];
    int                exp_side;
    logic [ADDR_W-1:0] exp_dst;
    int                beat;
    int                burst_idx;

    conv_burst_top u_dut (
        .clock,
        .clock_sreset,
        .s_address,
        .s_writedata,
        .s_readdata,
        .s_read,
        .s_write,
        .s_waitrequest,
        .m_address,
        .m_readdata,
        .m_writedata,
        .m_burstcount,
        .m_read,
        .m_write,
        .m_readdatavalid,
        .m_waitrequest
    );

    conv_mem_model #(.WORDS(MEM_WORDS), .SEED(RAND_SEED)) u_mem (
        .clock,
        .clock_sreset,
        .stall_enable,
        .address       (m_address),
        .burstcount    (m_burstcount),
        .read          (m_read),
        .write         (m_write),
        .writedata     (m_writedata),
        .readdata      (m_readdata),
        .readdatavalid (m_readdatavalid),
        .waitrequest   (m_waitrequest)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, the DUT never finished", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == mark) ? "ok" : "FAILED", errors - mark);
    endtask

    function automatic pixel_t fill_word(input int index);
        return pixel_t'((index * 40503) ^ 23130);   // odd multiplier, distinct per word
    endfunction

    // sum of the 3x3 neighbourhood, outside pixels are zero
    function automatic pixel_t expected_pixel(input int side, input int y, input int x);
        longint acc;
        int     yy;
        int     xx;
        acc = 0;
        for (int dy = 0; dy < KSIZE; dy++) begin
            for (int dx = 0; dx < KSIZE; dx++) begin
                yy = y + dy - 1;
                xx = x + dx - 1;
                if (yy >= 0 && yy < side && xx >= 0 && xx < side) begin
                    acc += longint'(img[yy*side+xx]) * longint'(ker[dy*KSIZE+dx]);
                end
            end
        end
        return pixel_t'(acc >>> FRAC_BITS);
    endfunction

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clock);
        s_address <= addr;
        s_writedata <= data;
        s_write <= 1'b1;
        @(posedge clock);
        assert (!s_waitrequest) else report_failure("register write was held by waitrequest");
        s_write <= 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [31:0] data);
        int waits;
        waits = 0;
        @(posedge clock);
        s_address <= addr;
        s_read <= 1'b1;
        @(posedge clock);
        while (s_waitrequest && waits < 16) begin
            waits++;
            @(posedge clock);
        end
        data = s_readdata;
        s_read <= 1'b0;
        check_equal("s_waitrequest cycles", waits, 1);
    endtask

    // kind 0 zero kernel, 1 identity, else random
    task automatic load_frame(input int side, input logic [ADDR_W-1:0] src,
                              input logic [ADDR_W-1:0] kaddr, input int kind);
        for (int i = 0; i < side * side; i++) begin
            img[i] = pixel_t'($random(seed));
            u_mem.mem[src / 2 + i] = img[i];
        end
        for (int k = 0; k < KWORDS; k++) begin
            case (kind)
                0: ker[k] = '0;
                1: ker[k] = (k == KWORDS / 2) ? pixel_t'(1 << FRAC_BITS) : '0;
                default: ker[k] = pixel_t'($random(seed) % 512);
            endcase
            u_mem.mem[kaddr / 2 + k] = ker[k];
        end
    endtask

    task automatic run_frame(input logic [RES_SEL_W-1:0] sel, input logic [ADDR_W-1:0] src,
                             input logic [ADDR_W-1:0] dst, input logic [ADDR_W-1:0] kaddr);
        logic [31:0] status;
        csr_write(CSR_RES, 32'(sel));
        csr_write(CSR_SRC, src);
        csr_write(CSR_DST, dst);
        csr_write(CSR_KER, kaddr);
        for (int i = 0; i < MEM_WORDS; i++) begin
            snapshot[i] = u_mem.mem[i];
        end
        exp_side = 8 << sel;
        exp_dst = dst;
        beat = 0;
        burst_idx = 0;
        csr_write(CSR_CTRL, 32'h1);
        csr_read(CSR_CTRL, status);
        check_equal("busy after go", status, 32'h1);
        while (status[0]) begin
            repeat (8) @(posedge clock);
            csr_read(CSR_CTRL, status);
        end
        check_equal("write bursts per frame", burst_idx, exp_side);
    endtask

    task automatic check_frame(input int side, input logic [ADDR_W-1:0] dst);
        int idx;
        for (int i = 0; i < MEM_WORDS; i++) begin
            idx = i - int'(dst / 2);
            if (idx >= 0 && idx < side * side) begin
                check_equal($sformatf("m_writedata y=%0d x=%0d", idx / side, idx % side),
                            u_mem.mem[i], expected_pixel(side, idx / side, idx % side));
            end
            else begin
                check_equal($sformatf("mem[%h]", 2 * i), u_mem.mem[i], snapshot[i]);
            end
        end
    endtask

    // bus monitor
    always @(posedge clock) begin
        if (!clock_sreset) begin
            if (m_read || m_write) begin
                assert (u_dut.busy) else report_failure("master request while busy is low");
            end
            if (m_write && !m_waitrequest) begin
                if (beat == 0) begin
                    check_equal("m_burstcount", m_burstcount, exp_side);
                    check_equal("m_address", m_address,
                                exp_dst + burst_idx * exp_side * BYTES_PER_PIXEL);
                end
                if (beat == exp_side - 1) begin
                    beat = 0;
                    burst_idx++;
                end
                else begin
                    beat++;
                end
            end
        end
    end

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        int          mark;
        clock_sreset = 1'b1;
        s_address = '0;
        s_writedata = '0;
        s_read = 1'b0;
        s_write = 1'b0;
        stall_enable = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] = fill_word(i);
        end
        repeat (4) @(posedge clock);
        clock_sreset <= 1'b0;

        mark = errors;
        csr_write(CSR_RES, 32'h3);
        csr_read(CSR_RES, data);
        check_equal("s_readdata RES", data, 32'h3);
        for (int a = CSR_SRC; a <= CSR_KER; a++) begin
            value = $random(seed);
            csr_write(CSR_ADDR_W'(a), value);
            csr_read(CSR_ADDR_W'(a), data);
            check_equal($sformatf("s_readdata reg %0d", a), data, value);
        end
        csr_read(CSR_CTRL, data);
        check_equal("s_readdata CTRL", data, 32'h0);
        finish_test("register readback", mark);

        mark = errors;
        load_frame(8, SRC_A, KER_A, 0);
        run_frame(2'd0, SRC_A, DST_A, KER_A);
        check_frame(8, DST_A);
        finish_test("busy protocol", mark);

        mark = errors;
        load_frame(8, SRC_A, KER_A, 1);
        run_frame(2'd0, SRC_A, DST_A, KER_A);
        check_frame(8, DST_A);
        for (int i = 0; i < 64; i++) begin
            check_equal("identity m_writedata", u_mem.mem[DST_A / 2 + i], img[i]);
        end
        finish_test("identity kernel side 8", mark);

        mark = errors;
        load_frame(8, SRC_A, KER_A, 2);
        run_frame(2'd0, SRC_A, DST_A, KER_A);
        check_frame(8, DST_A);
        for (int i = 0; i < 64; i++) begin
            prev_result[i] = u_mem.mem[DST_A / 2 + i];
        end
        finish_test("random kernel side 8", mark);

        mark = errors;
        @(posedge clock);
        stall_enable <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            u_mem.mem[DST_A / 2 + i] = fill_word(DST_A / 2 + i);  // wipe old results
        end
        run_frame(2'd0, SRC_A, DST_A, KER_A);
        check_frame(8, DST_A);
        for (int i = 0; i < 64; i++) begin
            check_equal("stalled m_writedata", u_mem.mem[DST_A / 2 + i], prev_result[i]);
        end
        finish_test("back-pressure", mark);

        mark = errors;
        load_frame(16, SRC_B, KER_B, 2);
        run_frame(2'd1, SRC_B, DST_B, KER_B);
        check_frame(16, DST_B);
        finish_test("side 16", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== conv_burst.f ====
rtl/conv_pkg.sv
rtl/conv_csr.sv
rtl/conv_fifo.sv
rtl/conv_sequencer.sv
rtl/conv_line_window.sv
rtl/conv_row_mac.sv
rtl/conv_row_sum.sv
rtl/conv_burst_top.sv
dv/conv_mem_model.sv
dv/conv_burst_tb.sv

// ==== Bender.yml ====
package:
  name: conv_burst

sources:
  - rtl/conv_pkg.sv
  - rtl/conv_csr.sv
  - rtl/conv_fifo.sv
  - rtl/conv_sequencer.sv
  - rtl/conv_line_window.sv
  - rtl/conv_row_mac.sv
  - rtl/conv_row_sum.sv
  - rtl/conv_burst_top.sv
  - target: simulation
    files:
      - dv/conv_mem_model.sv
      - dv/conv_burst_tb.sv
